//--- logic/fabric_pkg.sv
// load/store fabric shared definitions
// data, byte and GPIO widths
// address map bits and GPIO register indices
// address word with memory and peripheral views

package fabric_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // data and address width
  localparam int unsigned XLEN = 32;
  // bytes per word and byte offset width
  localparam int unsigned BLEN = XLEN/8;
  localparam int unsigned BLOG = $clog2(BLEN);
  // data memory word index, 1024 words
  localparam int unsigned MEM_ADR_W = 10;
  localparam int unsigned MEM_DEPTH = 2**MEM_ADR_W;
  // GPIO width
  localparam int unsigned GW = 32;

  //////////////////////////////
  // address map
  //////////////////////////////

  // peripherals when set, data memory when clear
  localparam int unsigned REGION_BIT  = 16;
  // UART slot when set, GPIO when clear
  localparam int unsigned PER_SEL_BIT = 6;

  // GPIO register indices, index 3 reserved
  localparam int unsigned GPIO_REG_W   = 2;
  localparam int unsigned GPIO_REG_OUT = 0;
  localparam int unsigned GPIO_REG_ENA = 1;
  localparam int unsigned GPIO_REG_IN  = 2;

  // field widths of the two address views
  localparam int unsigned MEM_UPR_W = XLEN - MEM_ADR_W - BLOG;
  localparam int unsigned PER_UPR_W = XLEN - 1 - PER_SEL_BIT;
  localparam int unsigned PER_UNU_W = PER_SEL_BIT - GPIO_REG_W - BLOG;

  //////////////////////////////
  // address views
  //////////////////////////////

  // memory view, region bit sits inside upr
  typedef struct packed {
    logic [MEM_UPR_W-1:0]  upr;
    logic [MEM_ADR_W-1:0]  idx;
    logic [BLOG-1:0]       off;
  } lsu_adr_mem_t;

  // peripheral view
  typedef struct packed {
    logic [PER_UPR_W-1:0]  upr;
    logic                  sel;
    logic [PER_UNU_W-1:0]  unu;
    logic [GPIO_REG_W-1:0] idx;
    logic [BLOG-1:0]       off;
  } lsu_adr_per_t;

  typedef union packed {
    lsu_adr_mem_t mem;
    lsu_adr_per_t per;
  } lsu_adr_t;

endpackage: fabric_pkg

//--- logic/lsu_req_if.sv
// decoded load/store request
// driven by the decoder, read by targets and response stage

interface lsu_req_if;

  // request strobe
  logic                           vld;
  // write enable
  logic                           wen;
  // address, memory or peripheral view
  fabric_pkg::lsu_adr_t           adr;
  // byte enables
  logic [fabric_pkg::BLEN-1:0]    ben;
  // write data
  logic [fabric_pkg::XLEN-1:0]    wdt;
  // one-hot region strobes, qualified by vld
  logic                           sel_mem;
  logic                           sel_gpio;
  logic                           sel_err;

  // decoder side
  modport dec (output vld, wen, adr, ben, wdt, sel_mem, sel_gpio, sel_err);

  // memory and GPIO targets
  modport tgt (input  vld, wen, adr, ben, wdt, sel_mem, sel_gpio);

  // response stage
  modport rsp (input  vld, sel_err);

endinterface: lsu_req_if

//--- logic/lsu_decoder.sv
// stage 1 of the load/store fabric
// request register and region decoder

module lsu_decoder (
  // system signals
  input  logic                          clk,
  input  logic                          arst_n,
  // requester strobes
  input  logic                          bus_vld,
  input  logic                          bus_wen,
  input  logic [fabric_pkg::XLEN-1:0]   bus_adr,
  input  logic [fabric_pkg::BLEN-1:0]   bus_ben,
  input  logic [fabric_pkg::XLEN-1:0]   bus_wdt,
  // registered request
  lsu_req_if.dec                        req
);

  //////////////////////////////
  // region decode
  //////////////////////////////

  // address seen through the peripheral view
  fabric_pkg::lsu_adr_t adr_u;

  logic dec_mem;
  logic dec_gpio;
  logic dec_err;

  assign adr_u = bus_adr;

  // region bit clear, memory
  // bits between word index and region bit ignored, so memory aliases
  assign dec_mem  = bus_vld & ~bus_adr[fabric_pkg::REGION_BIT];
  // region bit set, slot bit picks GPIO or the dead UART slot
  assign dec_gpio = bus_vld &  bus_adr[fabric_pkg::REGION_BIT] & ~adr_u.per.sel;
  assign dec_err  = bus_vld &  bus_adr[fabric_pkg::REGION_BIT] &  adr_u.per.sel;

  //////////////////////////////
  // request register
  //////////////////////////////

  // control, cleared by reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req.vld      <= 1'b0;
      req.sel_mem  <= 1'b0;
      req.sel_gpio <= 1'b0;
      req.sel_err  <= 1'b0;
    end else begin
      req.vld      <= bus_vld;
      // strobes already 0 with no request
      req.sel_mem  <= dec_mem;
      req.sel_gpio <= dec_gpio;
      req.sel_err  <= dec_err;
    end
  end

  // payload, only loaded with a request
  always_ff @(posedge clk) begin
    if (bus_vld) begin
      req.wen <= bus_wen;
      req.adr <= adr_u;
      req.ben <= bus_ben;
      req.wdt <= bus_wdt;
    end
  end

endmodule: lsu_decoder

//--- logic/data_memory.sv
// stage 2 of the load/store fabric
// byte-enabled synchronous data RAM, 1 cycle read

module data_memory (
  // system signals
  input  logic                          clk,
  // decoded request
  lsu_req_if.tgt                        req,
  // read data, 0 unless a selected read
  output logic [fabric_pkg::XLEN-1:0]   rdt
);

  //////////////////////////////
  // storage
  //////////////////////////////

  logic [fabric_pkg::XLEN-1:0] mem [0:fabric_pkg::MEM_DEPTH-1];

  // word index from the memory view
  logic [fabric_pkg::MEM_ADR_W-1:0] idx;

  // access qualifiers
  logic wr_ena;
  logic rd_ena;

  assign idx    = req.adr.mem.idx;
  assign wr_ena = req.sel_mem &  req.wen;
  assign rd_ena = req.sel_mem & ~req.wen;

  //////////////////////////////
  // write and read ports
  //////////////////////////////

  // per-byte write
  always_ff @(posedge clk) begin
    if (wr_ena) begin
      for (int b = 0; b < fabric_pkg::BLEN; b++) begin
        if (req.ben[b]) begin
          mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
        end
      end
    end
  end

  // registered read, zero otherwise
  // lets the response stage OR target data
  always_ff @(posedge clk) begin
    if (rd_ena) begin
      rdt <= mem[idx];
    end else begin
      rdt <= '0;
    end
  end

endmodule: data_memory

//--- logic/gpio_ctrl.sv
// stage 2 of the load/store fabric
// GPIO output and enable registers with byte writes
// two-flop input synchronizer and register readback

module gpio_ctrl (
  // system signals
  input  logic                          clk,
  input  logic                          arst_n,
  // decoded request
  lsu_req_if.tgt                        req,
  // read data, 0 unless a selected read
  output logic [fabric_pkg::XLEN-1:0]   rdt,
  // GPIO pins
  output logic [fabric_pkg::GW-1:0]     gpio_o,
  output logic [fabric_pkg::GW-1:0]     gpio_e,
  input  logic [fabric_pkg::GW-1:0]     gpio_i
);

  // byte-enabled merge of write data into a register
  function automatic logic [fabric_pkg::GW-1:0] ben_merge (
    input logic [fabric_pkg::GW-1:0]   old_val,
    input logic [fabric_pkg::XLEN-1:0] wdt,
    input logic [fabric_pkg::BLEN-1:0] ben
  );
    logic [fabric_pkg::GW-1:0] val;
    val = old_val;
    for (int b = 0; b < fabric_pkg::BLEN; b++) begin
      if (ben[b]) val[8*b +: 8] = wdt[8*b +: 8];
    end
    return val;
  endfunction: ben_merge

  // register index from the peripheral view
  logic [fabric_pkg::GPIO_REG_W-1:0] idx;

  // input synchronizer stages
  logic [fabric_pkg::GW-1:0] gpio_meta;
  logic [fabric_pkg::GW-1:0] gpio_sync;

  assign idx = req.adr.per.idx;

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      gpio_o <= '0;
      gpio_e <= '0;
    end else if (req.sel_gpio && req.wen) begin
      // input and reserved slots ignore writes
      if (idx == fabric_pkg::GPIO_REG_W'(fabric_pkg::GPIO_REG_OUT)) begin
        gpio_o <= ben_merge(gpio_o, req.wdt, req.ben);
      end
      if (idx == fabric_pkg::GPIO_REG_W'(fabric_pkg::GPIO_REG_ENA)) begin
        gpio_e <= ben_merge(gpio_e, req.wdt, req.ben);
      end
    end
  end

  // pins are asynchronous to clk
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      gpio_meta <= '0;
      gpio_sync <= '0;
    end else begin
      gpio_meta <= gpio_i;
      gpio_sync <= gpio_meta;
    end
  end

  //////////////////////////////
  // readback
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdt <= '0;
    end else if (req.sel_gpio && !req.wen) begin
      case (idx)
        fabric_pkg::GPIO_REG_W'(fabric_pkg::GPIO_REG_OUT): rdt <= gpio_o;
        fabric_pkg::GPIO_REG_W'(fabric_pkg::GPIO_REG_ENA): rdt <= gpio_e;
        fabric_pkg::GPIO_REG_W'(fabric_pkg::GPIO_REG_IN):  rdt <= gpio_sync;
        // reserved slot
        default:                                           rdt <= '0;
      endcase
    end else begin
      rdt <= '0;
    end
  end

endmodule: gpio_ctrl

//--- logic/lsu_response.sv
// stage 3 of the load/store fabric
// response valid, error flag and merged read data

module lsu_response (
  // system signals
  input  logic                          clk,
  input  logic                          arst_n,
  // decoded request
  lsu_req_if.rsp                        req,
  // target read data, already 0 when not selected
  input  logic [fabric_pkg::XLEN-1:0]   mem_rdt,
  input  logic [fabric_pkg::XLEN-1:0]   gpio_rdt,
  // response to the requester
  output logic                          bus_rsp_vld,
  output logic [fabric_pkg::XLEN-1:0]   bus_rdt,
  output logic                          bus_err
);

  //////////////////////////////
  // delayed strobes
  //////////////////////////////

  // aligned with registered target data
  logic vld_q;
  logic err_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      vld_q <= req.vld;
      // dead UART slot answers every access with an error
      err_q <= req.sel_err;
    end
  end

  //////////////////////////////
  // response
  //////////////////////////////

  assign bus_rsp_vld = vld_q;
  assign bus_err     = err_q;

  // at most one target is selected, so OR acts as a mux
  // error slot and writes leave both inputs at 0
  assign bus_rdt = mem_rdt | gpio_rdt;

endmodule: lsu_response

//--- logic/lsu_fabric_top.sv
// load/store fabric top level
// plain requester and GPIO ports
// decoder, data memory, GPIO and response stage instances

module lsu_fabric_top (
  // system signals
  input  logic                          clk,
  input  logic                          arst_n,
  // requester, one access per cycle
  input  logic                          bus_vld,
  input  logic                          bus_wen,
  input  logic [fabric_pkg::XLEN-1:0]   bus_adr,
  input  logic [fabric_pkg::BLEN-1:0]   bus_ben,
  input  logic [fabric_pkg::XLEN-1:0]   bus_wdt,
  // response, 2 cycles after the request
  output logic                          bus_rsp_vld,
  output logic [fabric_pkg::XLEN-1:0]   bus_rdt,
  output logic                          bus_err,
  // GPIO
  output logic [fabric_pkg::GW-1:0]     gpio_o,
  output logic [fabric_pkg::GW-1:0]     gpio_e,
  input  logic [fabric_pkg::GW-1:0]     gpio_i
);

  //////////////////////////////
  // local signals
  //////////////////////////////

  // registered request
  lsu_req_if req ();

  // target read data
  logic [fabric_pkg::XLEN-1:0] mem_rdt;
  logic [fabric_pkg::XLEN-1:0] gpio_rdt;

  //////////////////////////////
  // stages
  //////////////////////////////

  // stage 1, register and decode
  lsu_decoder dec (
    .clk     (clk),
    .arst_n  (arst_n),
    .bus_vld (bus_vld),
    .bus_wen (bus_wen),
    .bus_adr (bus_adr),
    .bus_ben (bus_ben),
    .bus_wdt (bus_wdt),
    .req     (req.dec)
  );

  // stage 2, data memory
  data_memory dmem (
    .clk (clk),
    .req (req.tgt),
    .rdt (mem_rdt)
  );

  // stage 2, GPIO controller
  gpio_ctrl gpio (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req.tgt),
    .rdt    (gpio_rdt),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e),
    .gpio_i (gpio_i)
  );

  // stage 3, merge and respond
  lsu_response rsp (
    .clk         (clk),
    .arst_n      (arst_n),
    .req         (req.rsp),
    .mem_rdt     (mem_rdt),
    .gpio_rdt    (gpio_rdt),
    .bus_rsp_vld (bus_rsp_vld),
    .bus_rdt     (bus_rdt),
    .bus_err     (bus_err)
  );

endmodule: lsu_fabric_top

//--- verif/lsu_fabric_tb.sv
// load/store fabric testbench
// LFSR random traffic over data memory, GPIO and the error slot
// reference model, expected response queue, compare tasks, cycle limit

module lsu_fabric_tb;

  // about 2000 cycles of traffic and a margin to the limit
  localparam int N_FILL         = 128;
  localparam int N_MEM          = 256;
  localparam int N_MIX          = 700;
  localparam int TIMEOUT_CYCLES = 3000;

  logic                        clk;
  logic                        arst_n;
  logic                        bus_vld;
  logic                        bus_wen;
  logic [fabric_pkg::XLEN-1:0] bus_adr;
  logic [fabric_pkg::BLEN-1:0] bus_ben;
  logic [fabric_pkg::XLEN-1:0] bus_wdt;
  logic                        bus_rsp_vld;
  logic [fabric_pkg::XLEN-1:0] bus_rdt;
  logic                        bus_err;
  logic [fabric_pkg::GW-1:0]   gpio_o;
  logic [fabric_pkg::GW-1:0]   gpio_e;
  logic [fabric_pkg::GW-1:0]   gpio_i;

  // model state
  logic [fabric_pkg::XLEN-1:0] mem_m [0:fabric_pkg::MEM_DEPTH-1];
  logic [fabric_pkg::GW-1:0]   gpo_m;
  logic [fabric_pkg::GW-1:0]   gpe_m;
  // model GPIO outputs delayed to the write edge
  logic [fabric_pkg::GW-1:0]   gpo_d1;
  logic [fabric_pkg::GW-1:0]   gpo_d2;
  logic [fabric_pkg::GW-1:0]   gpe_d1;
  logic [fabric_pkg::GW-1:0]   gpe_d2;
  // expected responses oldest first
  logic [fabric_pkg::XLEN-1:0] exp_rdt_q [$];
  logic                        exp_err_q [$];
  int                          exp_due_q [$];
  int                          neg_cnt;
  int                          cyc_cnt;
  int                          req_cnt;
  int                          rsp_cnt;
  logic [31:0]                 lfsr_state;
  // stimulus scratch
  logic [fabric_pkg::XLEN-1:0] s_adr;
  logic [fabric_pkg::XLEN-1:0] s_wdt;
  logic [fabric_pkg::BLEN-1:0] s_ben;
  logic                        s_wen;
  logic [6:0]                  s_idx;
  logic [3:0]                  s_ali;
  logic [1:0]                  s_off;

  lsu_fabric_top dut (
    .clk (clk), .arst_n (arst_n),
    .bus_vld (bus_vld), .bus_wen (bus_wen), .bus_adr (bus_adr),
    .bus_ben (bus_ben), .bus_wdt (bus_wdt),
    .bus_rsp_vld (bus_rsp_vld), .bus_rdt (bus_rdt), .bus_err (bus_err),
    .gpio_o (gpio_o), .gpio_e (gpio_e), .gpio_i (gpio_i)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] apply_byte_writes(input logic [31:0] old_val,
                                                    input logic [31:0] wdt,
                                                    input logic [3:0]  ben);
    logic [31:0] v;
    v = old_val;
    for (int b = 0; b < 4; b++) begin
      if (ben[b]) v[8*b +: 8] = wdt[8*b +: 8];
    end
    return v;
  endfunction

  // memory region with bits 15:12 aliasing onto the same word
  function automatic logic [31:0] mem_adr(input logic [6:0] idx, input logic [3:0] alias_bits,
                                          input logic [1:0] off);
    return {15'd0, 1'b0, alias_bits, 3'd0, idx, off};
  endfunction

  function automatic logic [31:0] gpio_adr(input logic [1:0] reg_idx);
    return {15'd0, 1'b1, 9'd0, 1'b0, 2'd0, reg_idx, 2'd0};
  endfunction

  // UART slot with bit 6 set
  function automatic logic [31:0] err_adr(input logic [8:0] hi, input logic [5:0] lo);
    return {15'd0, 1'b1, hi, 1'b1, lo};
  endfunction

  // fill word mixes every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] adr);
    return (adr * 32'h9e37_79b1) ^ {adr[15:0], adr[31:16]};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_word(input string name, input logic [fabric_pkg::XLEN-1:0] got,
                            input logic [fabric_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("error t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("error t=%0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic drive_req(input logic wen, input logic [31:0] adr,
                           input logic [3:0] ben, input logic [31:0] wdt);
    @(posedge clk);
    bus_vld <= 1'b1;
    bus_wen <= wen;
    bus_adr <= adr;
    bus_ben <= ben;
    bus_wdt <= wdt;
  endtask

  task automatic drive_idle(input int n);
    repeat (n) begin
      @(posedge clk);
      bus_vld <= 1'b0;
    end
  endtask

  // reference behaviour of one request and its model update
  task automatic model_access(input logic wen, input logic [31:0] adr, input logic [3:0] ben,
                              input logic [31:0] wdt, output logic [31:0] rdt,
                              output logic err);
    logic [9:0] idx;
    idx = adr[11:2];
    rdt = '0;
    err = 1'b0;
    if (!adr[fabric_pkg::REGION_BIT]) begin
      if (wen) mem_m[idx] = apply_byte_writes(mem_m[idx], wdt, ben);
      else rdt = mem_m[idx];
    end else if (adr[fabric_pkg::PER_SEL_BIT]) begin
      err = 1'b1;
    end else if (wen) begin
      // input and reserved registers are read only
      if (adr[3:2] == 2'd0) gpo_m = apply_byte_writes(gpo_m, wdt, ben);
      if (adr[3:2] == 2'd1) gpe_m = apply_byte_writes(gpe_m, wdt, ben);
    end else begin
      case (adr[3:2])
        2'd0:    rdt = gpo_m;
        2'd1:    rdt = gpe_m;
        2'd2:    rdt = gpio_i;
        default: rdt = '0;
      endcase
    end
  endtask

  //////////////////////////////
  // monitor and limit
  //////////////////////////////

  always @(posedge clk) begin
    cyc_cnt++;
    if (cyc_cnt >= TIMEOUT_CYCLES) abort_run("timeout, run did not finish within the cycle limit");
  end

  // outputs settle half a cycle after the edge
  always @(negedge clk) begin : monitor
    logic        exp_vld;
    logic [31:0] m_rdt;
    logic        m_err;
    neg_cnt++;
    exp_vld = (exp_due_q.size() != 0) && (exp_due_q[0] == neg_cnt);
    if (bus_rsp_vld !== exp_vld) begin
      if (exp_vld) abort_run("expected response did not arrive 2 cycles after its request");
      else abort_run("response seen with no matching request");
    end
    if (exp_vld) begin
      check_word("bus_rdt", bus_rdt, exp_rdt_q.pop_front());
      check_bit("bus_err", bus_err, exp_err_q.pop_front());
      void'(exp_due_q.pop_front());
      rsp_cnt++;
    end else begin
      check_bit("bus_err", bus_err, 1'b0);
    end
    // GPIO writes land two cycles after the request is seen
    check_word("gpio_o", gpio_o, gpo_d2);
    check_word("gpio_e", gpio_e, gpe_d2);
    gpo_d2 = gpo_d1;
    gpe_d2 = gpe_d1;
    if (bus_vld === 1'b1) begin
      model_access(bus_wen, bus_adr, bus_ben, bus_wdt, m_rdt, m_err);
      exp_rdt_q.push_back(m_rdt);
      exp_err_q.push_back(m_err);
      exp_due_q.push_back(neg_cnt + 2);
      req_cnt++;
    end
    gpo_d1 = gpo_m;
    gpe_d1 = gpe_m;
  end

  //////////////////////////////
  // stimulus
  //////////////////////////

  initial begin : stimulus
    logic [1:0] r;
    arst_n = 1'b0;
    bus_vld = 1'b0;
    bus_wen = 1'b0;
    bus_adr = '0;
    bus_ben = '0;
    bus_wdt = '0;
    gpio_i = '0;
    gpo_m = '0;
    gpe_m = '0;
    gpo_d1 = '0;
    gpo_d2 = '0;
    gpe_d1 = '0;
    gpe_d2 = '0;
    neg_cnt = 0;
    cyc_cnt = 0;
    req_cnt = 0;
    rsp_cnt = 0;
    lfsr_state = 32'h55c9;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;

    // reset values
    @(negedge clk);
    check_bit("bus_rsp_vld", bus_rsp_vld, 1'b0);
    check_bit("bus_err", bus_err, 1'b0);
    check_word("gpio_o", gpio_o, '0);
    check_word("gpio_e", gpio_e, '0);

    // fill the test window then random byte writes and aliased reads
    for (int i = 0; i < N_FILL; i++) begin
      s_adr = mem_adr(7'(i), 4'd0, 2'd0);
      drive_req(1'b1, s_adr, 4'hf, fill_word(s_adr));
    end
    for (int i = 0; i < 2 * N_MEM; i++) begin
      s_idx = 7'(rand_bits(7));
      s_ali = 4'(rand_bits(4));
      s_off = 2'(rand_bits(2));
      s_ben = 4'(rand_bits(4));
      s_wdt = rand_bits(32);
      drive_req(i < N_MEM, mem_adr(s_idx, s_ali, s_off), s_ben, s_wdt);
    end
    drive_idle(4);

    // GPIO byte writes including reserved and input slots
    for (int i = 0; i < 24; i++) begin
      r = 2'(rand_bits(2));
      s_ben = 4'(rand_bits(4));
      s_wdt = rand_bits(32);
      drive_req(1'b1, gpio_adr(r), s_ben, s_wdt);
    end
    for (int i = 0; i < 4; i++) drive_req(1'b0, gpio_adr(2'(i)), 4'hf, '0);
    drive_idle(4);

    // new input value then idle gap for the synchronizer
    @(posedge clk);
    gpio_i <= rand_bits(32);
    drive_idle(4);
    drive_req(1'b0, gpio_adr(2'd2), 4'hf, '0);
    drive_idle(4);

    // UART slot errors then proof that no state moved
    for (int i = 0; i < 12; i++) begin
      s_wen = 1'(rand_bits(1));
      s_wdt = rand_bits(32);
      drive_req(s_wen, err_adr(9'(rand_bits(9)), 6'(rand_bits(6))), 4'hf, s_wdt);
    end
    drive_req(1'b0, gpio_adr(2'd0), 4'hf, '0);
    drive_req(1'b0, gpio_adr(2'd1), 4'hf, '0);
    for (int i = 0; i < 4; i++) drive_req(1'b0, mem_adr(7'(rand_bits(7)), 4'd0, 2'd0), 4'hf, '0);
    drive_idle(4);

    // mixed traffic with random gaps
    for (int i = 0; i < N_MIX; i++) begin
      r = 2'(rand_bits(2));
      s_wen = 1'(rand_bits(1));
      s_ben = 4'(rand_bits(4));
      s_wdt = rand_bits(32);
      s_idx = 7'(rand_bits(7));
      s_ali = 4'(rand_bits(4));
      s_off = 2'(rand_bits(2));
      case (r)
        2'd0, 2'd1: s_adr = mem_adr(s_idx, s_ali, s_off);
        2'd2:       s_adr = gpio_adr(s_off);
        default:    s_adr = err_adr({s_ali, 5'd0}, {s_idx[3:0], s_off});
      endcase
      drive_req(s_wen, s_adr, s_ben, s_wdt);
      if (rand_bits(1) == 32'd1) drive_idle(int'(rand_bits(2)));
    end
    drive_idle(6);

    $display("requests %0d responses %0d cycles %0d", req_cnt, rsp_cnt, cyc_cnt);
    if (exp_due_q.size() != 0 || rsp_cnt != req_cnt) begin
      abort_run("responses still outstanding at end of run");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule: lsu_fabric_tb

//--- compile.f
logic/fabric_pkg.sv
logic/lsu_req_if.sv
logic/lsu_decoder.sv
logic/data_memory.sv
logic/gpio_ctrl.sv
logic/lsu_response.sv
logic/lsu_fabric_top.sv
verif/lsu_fabric_tb.sv

//--- run.sh
#!/bin/sh
# build and run the load/store fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module lsu_fabric_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vlsu_fabric_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit 1
fi

exit 0
